/* sources.f */
+incdir+dv
hdl/spy_pkg.sv
hdl/spy_host_port.sv
hdl/core_state_capture.sv
hdl/core_status_flags.sv
hdl/spy_read_mux.sv
hdl/spy_bus_top.sv
dv/spy_bus_tb.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f sources.f --top-module spy_bus_tb -o spy_bus_sim > sim.log 2>&1 \
   && ./obj_dir/spy_bus_sim >> sim.log 2>&1 \
   || echo "Some tests failed" >> sim.log
grep -q "Some tests failed" sim.log && echo "simulation FAILED, see sim.log" && exit 1
echo "simulation PASSED"
exit 0

/* dv/spy_bus_tests.svh */
   // ----------------------------------------------------------
   // expected read words
   // ----------------------------------------------------------

   function automatic spy_word_t expected_flag1(input logic halt, input logic err);
      return (16'(flags_in.waiting) << 15) | (16'(flags_in.boot) << 13)
           | (16'(flags_in.promdisable) << 12) | (16'(halt) << 11) | (16'(err) << 10)
           | (16'(flags_in.ssdone) << 9) | (16'(flags_in.srun) << 8);
   endfunction

   function automatic spy_word_t expected_flag2();
      return (16'(flags_in.wmap) << 13) | (16'(flags_in.destspc) << 12)
           | (16'(flags_in.iwrited) << 11) | (16'(flags_in.imod) << 10)
           | (16'(flags_in.pdlwrite) << 9) | (16'(flags_in.spush) << 8)
           | (16'(core_in.ir[48]) << 5) | (16'(flags_in.nop) << 4)
           | (16'(flags_in.vmaok) << 3) | (16'(flags_in.jcond) << 2)
           | (16'(flags_in.pcs1) << 1) | 16'(flags_in.pcs0);
   endfunction

   function automatic spy_word_t pick_half(input logic [31:0] v, input logic high);
      return high ? v[31:16] : v[15:0];
   endfunction

   function automatic spy_word_t expected_word(input spy_sel_e sel);
      case (sel)
         IRH:                return core_in.ir[47:32];
         IRM:                return core_in.ir[31:16];
         IRL:                return core_in.ir[15:0];
         OBH, OBL:           return pick_half(ob_latched, sel == OBH);
         OBH_LIVE, OBL_LIVE: return pick_half(core_in.ob, sel == OBH_LIVE);
         AH, AL:             return pick_half(core_in.a, sel == AH);
         MH, ML:             return pick_half(core_in.m, sel == MH);
         MDH, MDL:           return pick_half(core_in.md, sel == MDH);
         VMAH, VMAL:         return pick_half(core_in.vma, sel == VMAH);
         DISK:               return 16'(core_in.disk_state);
         BD:                 return 16'(core_in.bd_state);
         PC:                 return 16'(core_in.pc);
         OPC:                return 16'(core_in.opc);
         SCRATCH:            return core_in.scratch;
         FLAG1:              return expected_flag1(1'b0, 1'b0);   // no pulses pending
         FLAG2:              return expected_flag2();
         default:            return 16'hffff;
      endcase
   endfunction

   // ----------------------------------------------------------
   // stimulus and read helpers
   // ----------------------------------------------------------

   task automatic randomize_inputs;
      logic [287:0] bits;
      logic [31:0]  f;
      int           i;
      for (i = 0; i < 9; i++) begin
         bits[i*32 +: 32] = xorshift();
      end
      f = xorshift();
      @(posedge clk);
      core_in           <= bits[$bits(core_state_t)-1:0];
      flags_in          <= f[17:0];
      flags_in.err      <= 1'b0;            // quiet until pulsed
      flags_in.stathalt <= 1'b0;
   endtask

   task automatic write_state;
      @(posedge clk);
      state_write <= 1'b1;
      ob_latched   = core_in.ob;
      @(posedge clk);
      state_write <= 1'b0;
   endtask

   task automatic check_read(input spy_sel_e sel, input spy_word_t exp);
      spy_rsp_t   r;
      logic [2:0] tag;
      tag      = next_tag;
      next_tag = next_tag + 3'd1;
      send_request(sel, tag);
      grant_credit();
      wait_response(r);
      check_value(32'(r.tag), 32'(tag), $sformatf("tag of selector %0d", sel));
      check_value(32'(r.data), 32'(exp), $sformatf("data of selector %0d", sel));
   endtask

   task automatic expect_quiet(input int cycles);
      int i;
      for (i = 0; i < cycles; i++) begin
         @(negedge clk);
         check_value(32'(rsp_valid), 32'd0, "rsp_valid with no response credit");
      end
   endtask

   // ----------------------------------------------------------
   // directed tests
   // ----------------------------------------------------------

   task automatic reset_behavior;
      spy_rsp_t r;
      int       i;
      for (i = 0; i < 8; i++) begin
         @(posedge clk);
         if (i == 7) begin
            reset <= 1'b0;
         end
         @(negedge clk);
         check_value(32'(rsp_valid), 32'd0, "rsp_valid around reset");
         check_value(32'(req_credit), 32'd0, "req_credit around reset");
      end
      randomize_inputs();
      send_request(PC, 3'd5);
      next_tag = 3'd6;
      expect_quiet(10);                     // request waits for a response credit
      grant_credit();
      wait_response(r);
      check_value(32'(r.tag), 32'd5, "tag of the held request");
      check_value(32'(r.data), 32'(expected_word(PC)), "data of the held request");
      check_read(SCRATCH, expected_word(SCRATCH));
   endtask

   task automatic selector_mapping;
      int s;
      randomize_inputs();
      write_state();
      for (s = 0; s <= int'(SCRATCH); s++) begin
         check_read(spy_sel_e'(5'(s)), expected_word(spy_sel_e'(5'(s))));
      end
   endtask

   task automatic ob_latch_vs_live;
      logic [31:0] live;
      randomize_inputs();
      write_state();
      live = ~ob_latched;
      @(posedge clk);
      core_in.ob <= live;                   // changed without a state write
      check_read(OBH, ob_latched[31:16]);
      check_read(OBL, ob_latched[15:0]);
      check_read(OBH_LIVE, live[31:16]);
      check_read(OBL_LIVE, live[15:0]);
   endtask

   task automatic sticky_flag_reads;
      randomize_inputs();
      @(posedge clk);
      flags_in.err      <= 1'b1;
      @(posedge clk);
      flags_in.err      <= 1'b0;
      flags_in.stathalt <= 1'b1;
      @(posedge clk);
      flags_in.stathalt <= 1'b0;
      check_read(FLAG1, expected_flag1(1'b1, 1'b1));
      check_read(FLAG1, expected_flag1(1'b0, 1'b0));   // cleared by the first read
      check_read(FLAG2, expected_flag2());
   endtask

   task automatic backpressure_order;
      spy_sel_e   picks [8] = '{AH, MDL, VMAH, SCRATCH, IRM, BD, PC, ML};
      logic [2:0] tags [REQ_DEPTH];
      spy_rsp_t   r;
      int         base_credits;
      int         base_rsps;
      int         i;
      randomize_inputs();
      @(negedge clk);
      base_credits = req_credit_count;
      base_rsps    = rsp_count;
      for (i = 0; i < REQ_DEPTH; i++) begin
         tags[i]  = next_tag;
         next_tag = next_tag + 3'd1;
         send_request(picks[i % 8], tags[i]);
      end
      expect_quiet(10);
      check_value(32'(host_credits), 32'd0, "host credits with a full queue");
      for (i = 0; i < REQ_DEPTH; i++) begin
         grant_credit();
         wait_response(r);
         check_value(32'(r.tag), 32'(tags[i]), "tag order under back-pressure");
         check_value(32'(r.data), 32'(expected_word(picks[i % 8])), "data under back-pressure");
      end
      @(negedge clk);
      check_value(32'(req_credit_count - base_credits), 32'(REQ_DEPTH), "req_credit pulses");
      check_value(32'(rsp_count - base_rsps), 32'(REQ_DEPTH), "responses seen");
   endtask

   task automatic invalid_selector_read;
      check_read(spy_sel_e'(5'd25), 16'hffff);
      check_read(spy_sel_e'(5'd31), 16'hffff);
   endtask

/* dv/spy_bus_tb.sv */
`timescale 1ns/1ns

module spy_bus_tb
   import spy_pkg::*;
();

   localparam int REQ_DEPTH  = 2;           // same depth as the DUT default
   localparam int WAIT_LIMIT = 40;          // cycles before a wait gives up

   logic        clk;
   logic        reset;
   logic        req_valid;
   spy_req_t    req;
   logic        rsp_credit;
   logic        state_write;
   core_state_t core_in;
   core_flags_t flags_in;
   logic        req_credit;
   logic        rsp_valid;
   spy_rsp_t    rsp;
   logic [31:0] rng_state;
   logic [2:0]  next_tag;
   logic [31:0] ob_latched;                 // ob at the last state write
   int          host_credits;               // request slots the host may still use
   int          req_credit_count;
   int          rsp_count;

   spy_bus_top #(
      .REQ_DEPTH (REQ_DEPTH)
   ) dut0 (.*);

   always #10 clk = ~clk;

   // host view of request credits, plus pulse counters
   always @(posedge clk) begin
      if (reset) begin
         host_credits     <= REQ_DEPTH;
         req_credit_count <= 0;
         rsp_count        <= 0;
      end else begin
         host_credits     <= host_credits - int'(req_valid) + int'(req_credit);
         req_credit_count <= req_credit_count + int'(req_credit);
         rsp_count        <= rsp_count + int'(rsp_valid);
      end
   end

   // ----------------------------------------------------------
   // helpers
   // ----------------------------------------------------------

   function automatic logic [31:0] xorshift();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         stop_run($sformatf("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic send_request(input spy_sel_e sel, input logic [2:0] tag);
      int waited;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (host_credits == 0 && waited < WAIT_LIMIT);
      if (host_credits == 0) begin
         stop_run("Timeout: the DUT never gave back a request credit.");
      end else begin
         @(posedge clk);
         req_valid <= 1'b1;
         req       <= '{sel: sel, tag: tag};
         @(posedge clk);
         req_valid <= 1'b0;
      end
   endtask

   task automatic grant_credit;
      @(posedge clk);
      rsp_credit <= 1'b1;                   // one response slot
      @(posedge clk);
      rsp_credit <= 1'b0;
   endtask

   task automatic wait_response(output spy_rsp_t r);
      int waited;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!rsp_valid && waited < WAIT_LIMIT);
      if (!rsp_valid) begin
         stop_run("Timeout: no response came back from the DUT.");
      end else begin
         r = rsp;
      end
   endtask

   `include "spy_bus_tests.svh"

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      req_valid   = 1'b0;
      req         = '0;
      rsp_credit  = 1'b0;
      state_write = 1'b0;
      core_in     = '0;
      flags_in    = '0;
      rng_state   = 32'd5467;
      next_tag    = '0;
      ob_latched  = '0;
      reset_behavior();
      selector_mapping();
      ob_latch_vs_live();
      sticky_flag_reads();
      backpressure_order();
      invalid_selector_read();
      $display("All tests passed");
      $finish;
   end

endmodule

/* hdl/spy_bus_top.sv */
`timescale 1ns/1ns

module spy_bus_top
   import spy_pkg::*;
#(
   parameter int REQ_DEPTH = 2
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        req_valid,
   input  spy_req_t    req,
   input  logic        rsp_credit,
   input  logic        state_write,
   input  core_state_t core_in,
   input  core_flags_t flags_in,
   output logic        req_credit,
   output logic        rsp_valid,
   output spy_rsp_t    rsp
);

   spy_sel_e    issue_sel;
   logic        issue;
   spy_word_t   read_word;
   core_state_t snap;
   logic [31:0] ob_last;
   spy_word_t   flag1_word;
   spy_word_t   flag2_word;

   // ----------------------------------------------------------
   // host side
   // ----------------------------------------------------------

   spy_host_port #(
      .REQ_DEPTH (REQ_DEPTH)
   ) port0 (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .rsp_credit (rsp_credit),
      .read_word  (read_word),
      .req_credit (req_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .issue_sel  (issue_sel),
      .issue      (issue)
   );

   // ----------------------------------------------------------
   // state capture and readout
   // ----------------------------------------------------------

   core_state_capture capture0 (
      .clk         (clk),
      .reset       (reset),
      .state_write (state_write),
      .core_in     (core_in),
      .snap        (snap),
      .ob_last     (ob_last)
   );

   core_status_flags flags0 (
      .clk        (clk),
      .reset      (reset),
      .flags_in   (flags_in),
      .ir_top     (core_in.ir[48]),   // shown in flag 2
      .issue      (issue),
      .issue_sel  (issue_sel),
      .flag1_word (flag1_word),
      .flag2_word (flag2_word)
   );

   spy_read_mux mux0 (
      .issue_sel  (issue_sel),
      .snap       (snap),
      .ob_last    (ob_last),
      .flag1_word (flag1_word),
      .flag2_word (flag2_word),
      .read_word  (read_word)
   );

endmodule

/* hdl/spy_read_mux.sv */
`timescale 1ns/1ns

module spy_read_mux
   import spy_pkg::*;
(
   input  spy_sel_e    issue_sel,
   input  core_state_t snap,
   input  logic [31:0] ob_last,
   input  spy_word_t   flag1_word,
   input  spy_word_t   flag2_word,
   output spy_word_t   read_word
);

   // ----------------------------------------------------------
   // selector decode
   // ----------------------------------------------------------

   always_comb begin
      case (issue_sel)
         IRH:      read_word = snap.ir[47:32];   // ir[48] is in flag 2
         IRM:      read_word = snap.ir[31:16];
         IRL:      read_word = snap.ir[15:0];
         OBH:      read_word = ob_last[31:16];
         OBL:      read_word = ob_last[15:0];
         OBH_LIVE: read_word = snap.ob[31:16];
         OBL_LIVE: read_word = snap.ob[15:0];
         DISK:     read_word = {11'b0, snap.disk_state};
         BD:       read_word = {4'b0, snap.bd_state};
         AH:       read_word = snap.a[31:16];
         AL:       read_word = snap.a[15:0];
         MH:       read_word = snap.m[31:16];
         ML:       read_word = snap.m[15:0];
         MDH:      read_word = snap.md[31:16];
         MDL:      read_word = snap.md[15:0];
         VMAH:     read_word = snap.vma[31:16];
         VMAL:     read_word = snap.vma[15:0];
         FLAG2:    read_word = flag2_word;
         OPC:      read_word = {2'b0, snap.opc};
         FLAG1:    read_word = flag1_word;
         PC:       read_word = {2'b0, snap.pc};
         SCRATCH:  read_word = snap.scratch;
         default:  read_word = 16'hffff;         // unknown selector
      endcase
   end

endmodule

/* hdl/core_status_flags.sv */
`timescale 1ns/1ns

module core_status_flags
   import spy_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  core_flags_t flags_in,
   input  logic        ir_top,
   input  logic        issue,
   input  spy_sel_e    issue_sel,
   output spy_word_t   flag1_word,
   output spy_word_t   flag2_word
);

   logic err_sticky;
   logic halt_sticky;
   logic flag1_read;

   assign flag1_read = issue && (issue_sel == FLAG1);

   // ----------------------------------------------------------
   // sticky error and halt
   // ----------------------------------------------------------

   // a new set in the clearing cycle wins over the clear
   always_ff @(posedge clk) begin
      if (reset) begin
         err_sticky  <= 1'b0;
         halt_sticky <= 1'b0;
      end else begin
         if (flags_in.err) begin
            err_sticky <= 1'b1;
         end else if (flag1_read) begin
            err_sticky <= 1'b0;
         end
         if (flags_in.stathalt) begin
            halt_sticky <= 1'b1;
         end else if (flag1_read) begin
            halt_sticky <= 1'b0;
         end
      end
   end

   // ----------------------------------------------------------
   // packed flag words
   // ----------------------------------------------------------

   assign flag1_word = {flags_in.waiting, 1'b0, flags_in.boot, flags_in.promdisable,
                        halt_sticky, err_sticky, flags_in.ssdone, flags_in.srun,
                        8'h00};                              // low byte unused

   assign flag2_word = {2'b00, flags_in.wmap, flags_in.destspc, flags_in.iwrited,
                        flags_in.imod, flags_in.pdlwrite, flags_in.spush,
                        2'b00, ir_top, flags_in.nop, flags_in.vmaok,
                        flags_in.jcond, flags_in.pcs1, flags_in.pcs0};

endmodule

/* hdl/core_state_capture.sv */
`timescale 1ns/1ns

module core_state_capture
   import spy_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        state_write,
   input  core_state_t core_in,
   output core_state_t snap,
   output logic [31:0] ob_last
);

   // ----------------------------------------------------------
   // output bus latch
   // ----------------------------------------------------------

   // ob as it was on the last state write, for OBH/OBL
   always_ff @(posedge clk) begin
      if (reset) begin
         ob_last <= '0;
      end else if (state_write) begin
         ob_last <= core_in.ob;
      end
   end

   // ----------------------------------------------------------
   // datapath bundle
   // ----------------------------------------------------------

   always_comb begin
      snap            = '0;
      snap.ir         = core_in.ir;
      snap.ob         = core_in.ob;           // live value, OBx_LIVE
      snap.a          = core_in.a;
      snap.m          = core_in.m;
      snap.md         = core_in.md;
      snap.vma        = core_in.vma;
      snap.pc         = core_in.pc;
      snap.opc        = core_in.opc;
      snap.scratch    = core_in.scratch;
      snap.disk_state = core_in.disk_state;   // widened later in the mux
      snap.bd_state   = core_in.bd_state;
   end

endmodule

/* hdl/spy_host_port.sv */
`timescale 1ns/1ns

module spy_host_port
   import spy_pkg::*;
#(
   parameter int REQ_DEPTH = 2
) (
   input  logic      clk,
   input  logic      reset,
   input  logic      req_valid,
   input  spy_req_t  req,
   input  logic      rsp_credit,
   input  spy_word_t read_word,
   output logic      req_credit,
   output logic      rsp_valid,
   output spy_rsp_t  rsp,
   output spy_sel_e  issue_sel,
   output logic      issue
);

   localparam int PTR_W  = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
   localparam int CNT_W  = $clog2(REQ_DEPTH + 1);
   localparam int CRED_W = 8;              // host never holds more than 255 slots

   spy_req_t          queue [REQ_DEPTH];   // circular request store
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  q_count;             // requests waiting
   logic [CRED_W-1:0] rsp_cred;            // responses the host can take
   spy_req_t          head;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(REQ_DEPTH - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   // ----------------------------------------------------------
   // request queue
   // ----------------------------------------------------------

   // host only sends while it holds a credit, so a push never overflows
   always_ff @(posedge clk) begin
      if (req_valid) begin
         queue[wr_ptr] <= req;
      end
   end

   assign head      = queue[rd_ptr];
   assign issue_sel = head.sel;            // mux looks at the head directly

   // issue needs something queued and room on the host side
   assign issue = (q_count != '0) && (rsp_cred != '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         q_count  <= '0;
         rsp_cred <= '0;
      end else begin
         if (req_valid) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (issue) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         q_count  <= q_count + CNT_W'(req_valid) - CNT_W'(issue);
         rsp_cred <= rsp_cred + CRED_W'(rsp_credit) - CRED_W'(issue);
      end
   end

   // ----------------------------------------------------------
   // response issue
   // ----------------------------------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         rsp_valid  <= 1'b0;
         req_credit <= 1'b0;
      end else begin
         rsp_valid  <= issue;
         req_credit <= issue;              // queue slot frees as the response leaves
      end
   end

   // word is sampled in the issue cycle, so it shows live state
   always_ff @(posedge clk) begin
      if (issue) begin
         rsp <= '{data: read_word, tag: head.tag};
      end
   end

endmodule

/* hdl/spy_pkg.sv */
package spy_pkg;

   // ----------------------------------------------------------
   // read selectors
   // ----------------------------------------------------------

   typedef enum logic [4:0] {
      IRH      = 5'd0,   // ir[47:32]
      IRM      = 5'd1,
      IRL      = 5'd2,
      OBH      = 5'd3,   // latched output bus
      OBL      = 5'd4,
      OBH_LIVE = 5'd5,   // output bus as it is now
      OBL_LIVE = 5'd6,
      DISK     = 5'd7,
      BD       = 5'd8,
      AH       = 5'd9,
      AL       = 5'd10,
      MH       = 5'd11,
      ML       = 5'd12,
      MDH      = 5'd13,
      MDL      = 5'd14,
      VMAH     = 5'd15,
      VMAL     = 5'd16,
      FLAG2    = 5'd17,
      OPC      = 5'd18,
      FLAG1    = 5'd19,
      PC       = 5'd20,
      SCRATCH  = 5'd21
   } spy_sel_e;           // codes 22..31 read back as all ones

   typedef logic [15:0] spy_word_t;

   // ----------------------------------------------------------
   // processor state seen by the spy bus
   // ----------------------------------------------------------

   typedef struct packed {
      logic [48:0] ir;
      logic [31:0] ob;
      logic [31:0] a;
      logic [31:0] m;
      logic [31:0] md;
      logic [31:0] vma;
      logic [13:0] pc;
      logic [13:0] opc;
      logic [15:0] scratch;
      logic [4:0]  disk_state;
      logic [11:0] bd_state;
   } core_state_t;

   typedef struct packed {
      logic boot;
      logic err;          // raw error level, not yet sticky
      logic destspc;
      logic imod;
      logic iwrited;
      logic jcond;
      logic nop;
      logic pcs0;
      logic pcs1;
      logic pdlwrite;
      logic promdisable;
      logic spush;
      logic srun;
      logic ssdone;
      logic stathalt;
      logic vmaok;
      logic waiting;
      logic wmap;
   } core_flags_t;

   // ----------------------------------------------------------
   // host port payloads
   // ----------------------------------------------------------

   typedef struct packed {
      spy_sel_e   sel;
      logic [2:0] tag;    // chosen by host, echoed back
   } spy_req_t;

   typedef struct packed {
      spy_word_t  data;
      logic [2:0] tag;
   } spy_rsp_t;

endpackage
